// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= bitsyncTb
BUILD     ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD)

// ==== bitsync/auTimingDetector.sv ====
`timescale 1ns/1ps

module auTimingDetector (
    input  logic                  sampleClk,
    input  logic                  reset,
    input  logic                  auResampSync,
    input  bitsyncPkg::demodModeT demodMode,
    input  bitsyncPkg::sampleT    au,
    output bitsyncPkg::errorT     auTimingError,
    output logic                  auTimingErrorEn,
    output logic                  auBitsyncLock,
    output bitsyncPkg::lockCountT auLockCounter,
    symbolIf.source               symAu
);
    import bitsyncPkg::*;

    logic                        auEnable;
    logic                        auStrobe;
    logic                        auReset;
    sampleT                      auDelay;
    sampleT                      auFiltered;
    logic signed [sampleWidth:0] auSum;
    sampleT                      sr [2:0];
    phaseStateT                  phaseState;
    errorT                       nextError;
    logic                        transition;
    logic [sampleWidth-1:0]      offMag;
    logic [sampleWidth-1:0]      onMag;

    // Path only runs in AUQPSK, otherwise it sits cleared
    assign auEnable = (demodMode == modeAuqpsk);
    assign auStrobe = auResampSync && auEnable;
    assign auReset  = reset || !auEnable;

    assign auSum = auDelay + au;

    always_ff @(posedge sampleClk) begin
        if (auStrobe) begin
            auDelay    <= au;
            auFiltered <= auSum[sampleWidth:1];
            sr[0]      <= auFiltered;
            sr[1]      <= sr[0];
            sr[2]      <= sr[1];
        end
    end

    assign nextError = edgeError(sr[2], sr[1], sr[0]);

    always_ff @(posedge sampleClk) begin
        if (auReset) begin
            phaseState    <= onTime;
            auTimingError <= '0;
            transition    <= 1'b0;
            offMag        <= '0;
            onMag         <= '0;
        end else if (auStrobe) begin
            case (phaseState)
                onTime: phaseState <= offTime;
                offTime: begin
                    phaseState    <= onTime;
                    auTimingError <= nextError;
                    transition    <= sr[2][sampleWidth-1] != sr[0][sampleWidth-1];
                    offMag        <= magnitude(nextError);
                    onMag         <= magnitude(sr[2][sampleWidth-1] ? sr[0] : sr[2]);
                end
            endcase
        end
    end

    assign auTimingErrorEn = auStrobe && (phaseState == onTime);

    assign symAu.sym2xEn = auStrobe;
    assign symAu.symEn   = auTimingErrorEn;
    assign symAu.symData = sr[1];
    assign symAu.bitData = sr[1][sampleWidth-1];

    timingErrorIf lockIf ();

    assign lockIf.errorEn    = auTimingErrorEn;
    assign lockIf.transition = transition;
    assign lockIf.offTimeMag = offMag;
    assign lockIf.onTimeMag  = onMag;

    lockDetector auLock (
        .sampleClk   (sampleClk),
        .reset       (auReset),
        .strobe      (auStrobe),
        .errIn       (lockIf.lock),
        .locked      (auBitsyncLock),
        .lockCounter (auLockCounter)
    );

endmodule

// ==== bitsync/primaryTimingDetector.sv ====
`timescale 1ns/1ps

module primaryTimingDetector (
    input  logic                  sampleClk,
    input  logic                  reset,
    input  logic                  symTimes2Sync,
    input  bitsyncPkg::demodModeT demodMode,
    input  bitsyncPkg::sampleT    i,
    input  bitsyncPkg::sampleT    q,
    output bitsyncPkg::errorT     timingError,
    output logic                  timingErrorEn,
    output logic                  bitsyncLock,
    output bitsyncPkg::lockCountT lockCounter,
    symbolIf.source               symI,
    symbolIf.source               symQ
);
    import bitsyncPkg::*;

    //********************************************************************
    // Two-sample sum
    //********************************************************************
    sampleT                      iDelay;
    sampleT                      qDelay;
    sampleT                      iFiltered;
    sampleT                      qFiltered;
    logic signed [sampleWidth:0] iSum;
    logic signed [sampleWidth:0] qSum;

    assign iSum = iDelay + i;
    assign qSum = qDelay + q;

    always_ff @(posedge sampleClk) begin
        if (symTimes2Sync) begin
            iDelay    <= i;
            qDelay    <= q;
            iFiltered <= iSum[sampleWidth:1];
            qFiltered <= qSum[sampleWidth:1];
        end
    end

    //********************************************************************
    // Early/on/late shift registers
    //********************************************************************
    sampleT srI [2:0];
    sampleT srQ [3:0];
    logic   oqpsk;
    sampleT qEarly;
    sampleT qMid;
    sampleT qLate;

    always_ff @(posedge sampleClk) begin
        if (symTimes2Sync) begin
            srI[0] <= iFiltered;
            srI[1] <= srI[0];
            srI[2] <= srI[1];
            // BPSK carries I on both rails
            srQ[0] <= (demodMode == modeBpsk) ? iFiltered : qFiltered;
            srQ[1] <= srQ[0];
            srQ[2] <= srQ[1];
            srQ[3] <= srQ[2];
        end
    end

    // OQPSK taps Q one stage deeper, half a symbol behind I
    assign oqpsk  = (demodMode == modeOqpsk);
    assign qEarly = oqpsk ? srQ[3] : srQ[2];
    assign qMid   = oqpsk ? srQ[2] : srQ[1];
    assign qLate  = oqpsk ? srQ[1] : srQ[0];

    //********************************************************************
    // Phase state and timing error
    //********************************************************************
    phaseStateT                  phaseState;
    errorT                       errorI;
    errorT                       errorQ;
    errorT                       nextErrorI;
    sampleT                      onLevelI;
    logic                        transition;
    logic [sampleWidth-1:0]      offMag;
    logic [sampleWidth-1:0]      onMag;
    logic signed [sampleWidth:0] errSum;
    logic                        errorEn;

    assign nextErrorI = edgeError(srI[2], srI[1], srI[0]);
    // On-time level taken on the positive side of the edge
    assign onLevelI   = srI[2][sampleWidth-1] ? srI[0] : srI[2];

    always_ff @(posedge sampleClk) begin
        if (reset) begin
            phaseState <= onTime;
            errorI     <= '0;
            errorQ     <= '0;
            transition <= 1'b0;
            offMag     <= '0;
            onMag      <= '0;
        end else if (symTimes2Sync) begin
            case (phaseState)
                onTime: phaseState <= offTime;
                offTime: begin
                    phaseState <= onTime;
                    errorI     <= nextErrorI;
                    errorQ     <= edgeError(qEarly, qMid, qLate);
                    transition <= srI[2][sampleWidth-1] != srI[0][sampleWidth-1];
                    offMag     <= magnitude(nextErrorI);
                    onMag      <= magnitude(onLevelI);
                end
            endcase
        end
    end

    assign errorEn       = symTimes2Sync && (phaseState == onTime);
    assign timingErrorEn = errorEn;
    // Mean of the I and Q errors
    assign errSum        = errorI + errorQ;
    assign timingError   = errSum[sampleWidth:1];

    assign symI.sym2xEn = symTimes2Sync;
    assign symI.symEn   = errorEn;
    assign symI.symData = srI[1];
    assign symI.bitData = srI[1][sampleWidth-1];
    assign symQ.sym2xEn = symTimes2Sync;
    assign symQ.symEn   = errorEn;
    assign symQ.symData = qMid;
    assign symQ.bitData = qMid[sampleWidth-1];

    //********************************************************************
    // Lock detection on the I rail
    //********************************************************************
    timingErrorIf lockIf ();

    assign lockIf.errorEn    = errorEn;
    assign lockIf.transition = transition;
    assign lockIf.offTimeMag = offMag;
    assign lockIf.onTimeMag  = onMag;

    lockDetector primaryLock (
        .sampleClk   (sampleClk),
        .reset       (reset),
        .strobe      (symTimes2Sync),
        .errIn       (lockIf.lock),
        .locked      (bitsyncLock),
        .lockCounter (lockCounter)
    );

endmodule

// ==== common/bitsyncPkg.sv ====
package bitsyncPkg;

    // Sample and accumulator widths
    localparam int sampleWidth = 18;
    localparam int accumWidth  = 22;

    typedef logic signed [sampleWidth-1:0] sampleT;
    typedef logic signed [sampleWidth-1:0] errorT;
    typedef logic        [accumWidth-1:0]  accumT;
    typedef logic        [15:0]            lockCountT;

    // Lock detector window and vote limit
    localparam int        avgLength      = 16;
    localparam lockCountT lockCountLimit = 16'd4;

    typedef enum logic [1:0] {modeBpsk, modeQpsk, modeOqpsk, modeAuqpsk} demodModeT;
    typedef enum logic {onTime, offTime} phaseStateT;
    typedef enum logic {average, test} avgStateT;

    // Early/late error of one rail, zero without a sign change
    function automatic errorT edgeError(sampleT early, sampleT off, sampleT late);
        if (early[sampleWidth-1] == late[sampleWidth-1]) begin
            return '0;
        end
        return early[sampleWidth-1] ? off : -off;
    endfunction

    function automatic logic [sampleWidth-1:0] magnitude(sampleT x);
        return x[sampleWidth-1] ? -x : x;
    endfunction

endpackage

// ==== common/symbolIf.sv ====
`timescale 1ns/1ps

// Recovered clock enables and data of one rail
interface symbolIf;
    import bitsyncPkg::*;

    logic   sym2xEn;
    logic   symEn;
    sampleT symData;
    logic   bitData;

    modport source (
        output sym2xEn, symEn, symData, bitData
    );

    modport sink (
        input sym2xEn, symEn, symData, bitData
    );

endinterface

// ==== common/timingErrorIf.sv ====
`timescale 1ns/1ps

// Detector results handed to a lock detector
interface timingErrorIf;
    import bitsyncPkg::*;

    logic                   errorEn;
    logic                   transition;
    logic [sampleWidth-1:0] offTimeMag;
    logic [sampleWidth-1:0] onTimeMag;

    modport detector (
        output errorEn, transition, offTimeMag, onTimeMag
    );

    modport lock (
        input errorEn, transition, offTimeMag, onTimeMag
    );

endinterface

// ==== rtl/bitsyncTop.sv ====
`timescale 1ns/1ps

module bitsyncTop (
    input  logic                  sampleClk,
    input  logic                  reset,
    input  logic                  symTimes2Sync,
    input  logic                  auResampSync,
    input  bitsyncPkg::demodModeT demodMode,
    input  bitsyncPkg::sampleT    i,
    input  bitsyncPkg::sampleT    q,
    input  bitsyncPkg::sampleT    au,
    output bitsyncPkg::errorT     timingError,
    output logic                  timingErrorEn,
    output bitsyncPkg::errorT     auTimingError,
    output logic                  auTimingErrorEn,
    output logic                  iSym2xEn,
    output logic                  iSymEn,
    output logic                  bitDataI,
    output bitsyncPkg::sampleT    symDataI,
    output logic                  qSym2xEn,
    output logic                  qSymEn,
    output logic                  bitDataQ,
    output bitsyncPkg::sampleT    symDataQ,
    output logic                  bitsyncLock,
    output logic                  auBitsyncLock,
    output bitsyncPkg::lockCountT lockCounter,
    output bitsyncPkg::lockCountT auLockCounter
);

    symbolIf symI ();
    symbolIf symQ ();
    symbolIf symAu ();

    // Primary I/Q path
    primaryTimingDetector primary (
        .sampleClk     (sampleClk),
        .reset         (reset),
        .symTimes2Sync (symTimes2Sync),
        .demodMode     (demodMode),
        .i             (i),
        .q             (q),
        .timingError   (timingError),
        .timingErrorEn (timingErrorEn),
        .bitsyncLock   (bitsyncLock),
        .lockCounter   (lockCounter),
        .symI          (symI.source),
        .symQ          (symQ.source)
    );

    // Independent AU path on its own strobe
    auTimingDetector auPath (
        .sampleClk       (sampleClk),
        .reset           (reset),
        .auResampSync    (auResampSync),
        .demodMode       (demodMode),
        .au              (au),
        .auTimingError   (auTimingError),
        .auTimingErrorEn (auTimingErrorEn),
        .auBitsyncLock   (auBitsyncLock),
        .auLockCounter   (auLockCounter),
        .symAu           (symAu.source)
    );

    recoveredDataMux dataMux (
        .demodMode (demodMode),
        .symI      (symI.sink),
        .symQ      (symQ.sink),
        .symAu     (symAu.sink),
        .iSym2xEn  (iSym2xEn),
        .iSymEn    (iSymEn),
        .symDataI  (symDataI),
        .bitDataI  (bitDataI),
        .qSym2xEn  (qSym2xEn),
        .qSymEn    (qSymEn),
        .symDataQ  (symDataQ),
        .bitDataQ  (bitDataQ)
    );

endmodule

// ==== rtl/lockDetector.sv ====
`timescale 1ns/1ps

module lockDetector (
    input  logic                  sampleClk,
    input  logic                  reset,
    input  logic                  strobe,
    timingErrorIf.lock            errIn,
    output logic                  locked,
    output bitsyncPkg::lockCountT lockCounter
);
    import bitsyncPkg::*;

    avgStateT                      avgState;
    logic [$clog2(avgLength)-1:0]  avgCount;
    accumT                         offSum;
    accumT                         onSum;
    logic                          voteUp;

    // Off-time energy below half the on-time energy counts as a good window
    assign voteUp = offSum[accumWidth-1:14] <= {1'b0, onSum[accumWidth-1:15]};

    always_ff @(posedge sampleClk) begin
        if (reset) begin
            avgState    <= average;
            avgCount    <= $bits(avgCount)'(avgLength - 1);
            offSum      <= '0;
            onSum       <= '0;
            locked      <= 1'b0;
            lockCounter <= '0;
        end else if (strobe) begin
            case (avgState)
                average: begin
                    // Only symbols with a transition carry timing information
                    if (errIn.errorEn && errIn.transition) begin
                        offSum <= offSum + accumT'(errIn.offTimeMag);
                        onSum  <= onSum + accumT'(errIn.onTimeMag);
                        if (avgCount == '0) begin
                            avgState <= test;
                        end else begin
                            avgCount <= avgCount - 1'b1;
                        end
                    end
                end
                test: begin
                    avgState <= average;
                    avgCount <= $bits(avgCount)'(avgLength - 1);
                    offSum   <= '0;
                    onSum    <= '0;
                    // Vote counter, clears when it hits either limit
                    if (voteUp) begin
                        if (lockCounter == lockCountLimit) begin
                            locked      <= 1'b1;
                            lockCounter <= '0;
                        end else begin
                            lockCounter <= lockCounter + 16'd1;
                        end
                    end else begin
                        if (lockCounter == ~lockCountLimit) begin
                            locked      <= 1'b0;
                            lockCounter <= '0;
                        end else begin
                            lockCounter <= lockCounter - 16'd1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

// ==== rtl/recoveredDataMux.sv ====
`timescale 1ns/1ps

module recoveredDataMux (
    input  bitsyncPkg::demodModeT demodMode,
    symbolIf.sink                 symI,
    symbolIf.sink                 symQ,
    symbolIf.sink                 symAu,
    output logic                  iSym2xEn,
    output logic                  iSymEn,
    output bitsyncPkg::sampleT    symDataI,
    output logic                  bitDataI,
    output logic                  qSym2xEn,
    output logic                  qSymEn,
    output bitsyncPkg::sampleT    symDataQ,
    output logic                  bitDataQ
);
    import bitsyncPkg::*;

    always_comb begin
        iSym2xEn = symI.sym2xEn;
        iSymEn   = symI.symEn;
        symDataI = symI.symData;
        bitDataI = symI.bitData;
        // AUQPSK puts the independent stream on the Q outputs
        if (demodMode == modeAuqpsk) begin
            qSym2xEn = symAu.sym2xEn;
            qSymEn   = symAu.symEn;
            symDataQ = symAu.symData;
            bitDataQ = symAu.bitData;
        end else begin
            qSym2xEn = symQ.sym2xEn;
            qSymEn   = symQ.symEn;
            symDataQ = symQ.symData;
            bitDataQ = symQ.bitData;
        end
    end

endmodule

// ==== src.f ====
common/bitsyncPkg.sv
common/timingErrorIf.sv
common/symbolIf.sv
rtl/lockDetector.sv
bitsync/primaryTimingDetector.sv
bitsync/auTimingDetector.sv
rtl/recoveredDataMux.sv
rtl/bitsyncTop.sv
tests/bitsync_properties.sv
tests/bitsyncTb.sv

// ==== tests/bitsyncTb.sv ====
`timescale 1ns/1ps

module bitsyncTb;
    import bitsyncPkg::*;

    typedef struct {
        demodModeT mode;
        int        symbols;
        int        offset;
        int        amp;
        logic      expLock;
        logic      expAuLock;
    } rowT;

    localparam int numRows = 6;
    localparam int maxSamples = 1024;

    logic      sampleClk;
    logic      reset;
    logic      symTimes2Sync;
    logic      auResampSync;
    demodModeT demodMode;
    sampleT    i;
    sampleT    q;
    sampleT    au;
    errorT     timingError;
    logic      timingErrorEn;
    errorT     auTimingError;
    logic      auTimingErrorEn;
    logic      iSym2xEn;
    logic      iSymEn;
    logic      bitDataI;
    sampleT    symDataI;
    logic      qSym2xEn;
    logic      qSymEn;
    logic      bitDataQ;
    sampleT    symDataQ;
    logic      bitsyncLock;
    logic      auBitsyncLock;
    lockCountT lockCounter;
    lockCountT auLockCounter;

    rowT         rows [numRows];
    int          xi [maxSamples];
    int          xq [maxSamples];
    int          xa [maxSamples];
    logic [31:0] rngState;
    demodModeT   curMode;

    bitsyncTop UUT (.*);

    always #50 sampleClk = ~sampleClk;

    //**********************************************************************
    // Reference model
    //**********************************************************************
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Rail 0 is I, 1 is the primary Q rail, 2 is AU
    function automatic int railIn(input int rail, input int m);
        if (rail == 0) begin
            return xi[m];
        end else if (rail == 1) begin
            return (curMode == modeBpsk) ? xi[m] : xq[m];
        end
        return xa[m];
    endfunction

    function automatic int filtered(input int rail, input int m);
        return (railIn(rail, m - 1) + railIn(rail, m)) >>> 1;
    endfunction

    function automatic int edgeRef(input int early, input int off, input int late);
        if ((early < 0) == (late < 0)) begin
            return 0;
        end
        return (early < 0) ? off : -off;
    endfunction

    function automatic int railError(input int rail, input int newest);
        return edgeRef(filtered(rail, newest - 2), filtered(rail, newest - 1),
                       filtered(rail, newest));
    endfunction

    //**********************************************************************
    // Compare tasks
    //**********************************************************************
    task automatic compareSample(input string what, input sampleT got, input sampleT expected);
        if (got !== expected) begin
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic compareError(input string what, input errorT got, input errorT expected);
        if (got !== expected) begin
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic compareBit(input string what, input logic got, input logic expected);
        if (got !== expected) begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, expected);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic compareCount(input string what, input lockCountT got,
                                input lockCountT expected);
        if (got !== expected) begin
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    //**********************************************************************
    // Row execution
    //**********************************************************************
    task automatic checkCycle(input int n);
        logic even;
        logic oqpsk;
        int   qData;
        int   eI;
        int   eQ;
        even  = (n % 2 == 0);
        oqpsk = (curMode == modeOqpsk);
        compareBit("iSym2xEn", iSym2xEn, 1'b1);
        compareBit("qSym2xEn", qSym2xEn, 1'b1);
        compareBit("iSymEn", iSymEn, even);
        compareBit("qSymEn", qSymEn, even);
        compareBit("timingErrorEn", timingErrorEn, even);
        compareBit("lockCounter in range",
                   lockCounter <= lockCountLimit || lockCounter >= ~lockCountLimit, 1'b1);
        if (curMode == modeAuqpsk) begin
            qData = filtered(2, n - 3);
            compareBit("auTimingErrorEn", auTimingErrorEn, even);
        end else begin
            qData = oqpsk ? filtered(1, n - 4) : filtered(1, n - 3);
            compareBit("auTimingErrorEn", auTimingErrorEn, 1'b0);
            compareBit("auBitsyncLock", auBitsyncLock, 1'b0);
            compareCount("auLockCounter", auLockCounter, '0);
        end
        if (even) begin
            compareSample("symDataI", symDataI, sampleT'(filtered(0, n - 3)));
            compareBit("bitDataI", bitDataI, filtered(0, n - 3) < 0);
            compareSample("symDataQ", symDataQ, sampleT'(qData));
            compareBit("bitDataQ", bitDataQ, qData < 0);
            eI = railError(0, n - 3);
            eQ = railError(1, oqpsk ? n - 4 : n - 3);
            compareError("timingError", timingError, errorT'((eI + eQ) >>> 1));
            if (curMode == modeAuqpsk) begin
                compareError("auTimingError", auTimingError, errorT'(railError(2, n - 3)));
            end
        end
    endtask

    task automatic runRow(input rowT r);
        int   symI [maxSamples];
        int   symQ [maxSamples];
        int   symA [maxSamples];
        int   k;
        logic auMode;
        for (k = 0; k <= r.symbols; k++) begin
            rngState = xorshift(rngState);
            symI[k] = rngState[31] ? -r.amp : r.amp;
            symQ[k] = rngState[30] ? -r.amp : r.amp;
            symA[k] = rngState[29] ? -r.amp : r.amp;
        end
        // NRZ at two samples per symbol, shifted by the row's offset
        for (int n = 0; n < 2 * r.symbols; n++) begin
            xi[n] = symI[(n + r.offset) / 2];
            xq[n] = symQ[(n + r.offset) / 2];
            xa[n] = symA[(n + r.offset) / 2];
        end
        curMode = r.mode;
        auMode  = (r.mode == modeAuqpsk);
        @(posedge sampleClk);
        reset         <= 1'b1;
        demodMode     <= r.mode;
        symTimes2Sync <= 1'b0;
        auResampSync  <= 1'b0;
        repeat (3) @(posedge sampleClk);
        reset <= 1'b0;
        @(negedge sampleClk);
        compareBit("bitsyncLock after reset", bitsyncLock, 1'b0);
        compareBit("auBitsyncLock after reset", auBitsyncLock, 1'b0);
        compareCount("lockCounter after reset", lockCounter, '0);
        compareCount("auLockCounter after reset", auLockCounter, '0);
        compareBit("timingErrorEn after reset", timingErrorEn, 1'b0);
        compareBit("auTimingErrorEn after reset", auTimingErrorEn, 1'b0);
        compareError("timingError after reset", timingError, '0);
        compareError("auTimingError after reset", auTimingError, '0);
        for (int n = 0; n < 2 * r.symbols; n++) begin
            @(posedge sampleClk);
            symTimes2Sync <= 1'b1;
            auResampSync  <= 1'b1;
            i             <= sampleT'(xi[n]);
            q             <= sampleT'(xq[n]);
            au            <= sampleT'(xa[n]);
            @(negedge sampleClk);
            // Early samples still hold the previous row
            if (n >= 8) begin
                checkCycle(n);
            end
        end
        @(posedge sampleClk);
        symTimes2Sync <= 1'b0;
        auResampSync  <= 1'b0;
        @(negedge sampleClk);
        compareBit("bitsyncLock at row end", bitsyncLock, r.expLock);
        compareBit("auBitsyncLock at row end", auBitsyncLock, r.expAuLock);
        // Strobes apart, so the Q outputs show which path feeds them
        @(posedge sampleClk);
        auResampSync <= 1'b1;
        @(negedge sampleClk);
        compareBit("iSym2xEn on AU strobe", iSym2xEn, 1'b0);
        compareBit("timingErrorEn on AU strobe", timingErrorEn, 1'b0);
        compareBit("qSym2xEn on AU strobe", qSym2xEn, auMode);
        compareBit("qSymEn on AU strobe", qSymEn, auMode);
        @(posedge sampleClk);
        symTimes2Sync <= 1'b1;
        auResampSync  <= 1'b0;
        @(negedge sampleClk);
        compareBit("iSymEn on primary strobe", iSymEn, 1'b1);
        compareBit("auTimingErrorEn on primary strobe", auTimingErrorEn, 1'b0);
        compareBit("qSym2xEn on primary strobe", qSym2xEn, !auMode);
        compareBit("qSymEn on primary strobe", qSymEn, !auMode);
    endtask

    //**********************************************************************
    // Main sequence and watchdog
    //**********************************************************************
    initial begin
        sampleClk     = 1'b0;
        reset         = 1'b1;
        symTimes2Sync = 1'b0;
        auResampSync  = 1'b0;
        demodMode     = modeBpsk;
        i             = '0;
        q             = '0;
        au            = '0;
        rngState      = 32'h1cd3b604;
        curMode       = modeBpsk;
        rows[0] = '{modeBpsk,   400, 0, 60000, 1'b1, 1'b0};
        rows[1] = '{modeQpsk,   400, 0, 60000, 1'b1, 1'b0};
        rows[2] = '{modeOqpsk,  100, 0, 60000, 1'b0, 1'b0};
        // Half-symbol offset puts the edges on the on-time samples
        rows[3] = '{modeQpsk,   500, 1, 60000, 1'b0, 1'b0};
        rows[4] = '{modeAuqpsk, 400, 0, 60000, 1'b1, 1'b1};
        rows[5] = '{modeBpsk,   100, 0, 30000, 1'b0, 1'b0};
        for (int r = 0; r < numRows; r++) begin
            runRow(rows[r]);
        end
        $display("No errors");
        $finish;
    end

    initial begin
        longint limitNs;
        #1;
        limitNs = 1000;
        for (int r = 0; r < numRows; r++) begin
            limitNs += 2 * (2 * rows[r].symbols + 10) * 100;
        end
        #(limitNs);
        $display("Timeout: the test sequence did not complete in time");
        $display("Errors found");
        $fatal(1);
    end

endmodule

// ==== tests/bitsync_properties.sv ====
`timescale 1ns/1ps

module bitsyncProperties (
    input logic                  sampleClk,
    input logic                  reset,
    input logic                  strobe,
    input logic                  symEn,
    input logic                  sym2xEn,
    input logic                  errorEn,
    input logic                  locked,
    input bitsyncPkg::lockCountT lockCounter
);
    import bitsyncPkg::*;

    // errorEn seen on the previous strobe
    logic lastStrobeErr;

    always_ff @(posedge sampleClk) begin
        if (reset) begin
            lastStrobeErr <= 1'b0;
        end else if (strobe) begin
            lastStrobeErr <= errorEn;
        end
    end

    symEnInside2x: assert property (@(posedge sampleClk) disable iff (reset)
        symEn |-> sym2xEn)
        else $error("symEn without sym2xEn");

    errorEnAlternates: assert property (@(posedge sampleClk) disable iff (reset)
        (strobe && errorEn) |-> !lastStrobeErr)
        else $error("errorEn on two consecutive strobes");

    counterClearsOnLock: assert property (@(posedge sampleClk) disable iff (reset)
        $changed(locked) |-> lockCounter == '0)
        else $error("lock counter not cleared when lock changed");

endmodule

bind primaryTimingDetector bitsyncProperties primaryProps (
    .sampleClk   (sampleClk),
    .reset       (reset),
    .strobe      (symTimes2Sync),
    .symEn       (timingErrorEn),
    .sym2xEn     (symTimes2Sync),
    .errorEn     (timingErrorEn),
    .locked      (bitsyncLock),
    .lockCounter (lockCounter)
);

bind auTimingDetector bitsyncProperties auProps (
    .sampleClk   (sampleClk),
    .reset       (auReset),
    .strobe      (auStrobe),
    .symEn       (auTimingErrorEn),
    .sym2xEn     (auStrobe),
    .errorEn     (auTimingErrorEn),
    .locked      (auBitsyncLock),
    .lockCounter (auLockCounter)
);
